// File: design/div_rs_pkg.sv
`include "div_rs_cfg.svh"

package div_rs_pkg;

    typedef logic [`RS_IDX_W-1:0] rs_idx_t;

    typedef logic [`RS_TAG_W-1:0] tag_t;

    typedef logic [`RS_DATA_W-1:0] data_t;

    typedef logic [`RS_PC_W-1:0] pc_t;

    typedef enum logic [1:0] {
        op_div,  // signed quotient
        op_divu,
        op_rem,  // signed remainder
        op_remu
    } div_op_t;

    // four-phase dispatch handshake
    typedef enum logic [1:0] {
        disp_idle,    // ack low, waiting for req
        disp_ack,     // first cycle after the entry write
        disp_release  // ack held until req drops
    } disp_state_t;

endpackage

// File: design/div_rs_top.sv
`timescale 1ns/1ps
`include "div_rs_cfg.svh"

module div_rs_top (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   dispatch_req,
    input  div_rs_pkg::div_op_t                    disp_op,
    input  div_rs_pkg::pc_t                        disp_pc,
    input  div_rs_pkg::tag_t                       disp_dest,
    input  div_rs_pkg::tag_t                       disp_src1_tag,
    input  div_rs_pkg::data_t                      disp_src1_data,
    input  logic                                   disp_src1_valid,
    input  div_rs_pkg::tag_t                       disp_src2_tag,
    input  div_rs_pkg::data_t                      disp_src2_data,
    input  logic                                   disp_src2_valid,
    input  logic [`RS_NUM_BUS-1:0]                 bus_valid,
    input  div_rs_pkg::tag_t  [`RS_NUM_BUS-1:0]    bus_tag,
    input  div_rs_pkg::data_t [`RS_NUM_BUS-1:0]    bus_data,
    output logic                                   dispatch_ack,
    output logic                                   issue_valid,
    output div_rs_pkg::div_op_t                    issue_op,
    output div_rs_pkg::pc_t                        issue_pc,
    output div_rs_pkg::tag_t                       issue_dest,
    output div_rs_pkg::data_t                      issue_src1,
    output div_rs_pkg::data_t                      issue_src2
);

    import div_rs_pkg::*;

    logic    [`RS_ENTRIES-1:0] busy;
    logic    [`RS_ENTRIES-1:0] alloc;
    logic    [`RS_ENTRIES-1:0] ready;
    logic    [`RS_ENTRIES-1:0] grant;
    div_op_t [`RS_ENTRIES-1:0] ent_op;
    pc_t     [`RS_ENTRIES-1:0] ent_pc;
    tag_t    [`RS_ENTRIES-1:0] ent_dest;
    data_t   [`RS_ENTRIES-1:0] ent_src1;
    data_t   [`RS_ENTRIES-1:0] ent_src2;

    rs_dispatch_ctrl i_dispatch_ctrl (
        .clk          (clk),
        .reset        (reset),
        .dispatch_req (dispatch_req),
        .busy         (busy),
        .dispatch_ack (dispatch_ack),
        .alloc        (alloc)
    );

    // dispatch fields and buses fan out to every entry
    for (genvar e = 0; e < `RS_ENTRIES; e++) begin : g_entry
        rs_entry i_entry (
            .clk             (clk),
            .reset           (reset),
            .alloc           (alloc[e]),
            .disp_op         (disp_op),
            .disp_pc         (disp_pc),
            .disp_dest       (disp_dest),
            .disp_src1_tag   (disp_src1_tag),
            .disp_src1_data  (disp_src1_data),
            .disp_src1_valid (disp_src1_valid),
            .disp_src2_tag   (disp_src2_tag),
            .disp_src2_data  (disp_src2_data),
            .disp_src2_valid (disp_src2_valid),
            .bus_valid       (bus_valid),
            .bus_tag         (bus_tag),
            .bus_data        (bus_data),
            .grant           (grant[e]),
            .busy            (busy[e]),
            .ready           (ready[e]),
            .ent_op          (ent_op[e]),
            .ent_pc          (ent_pc[e]),
            .ent_dest        (ent_dest[e]),
            .ent_src1        (ent_src1[e]),
            .ent_src2        (ent_src2[e])
        );
    end

    rs_issue_select i_issue_select (
        .clk         (clk),
        .reset       (reset),
        .ready       (ready),
        .ent_op      (ent_op),
        .ent_pc      (ent_pc),
        .ent_dest    (ent_dest),
        .ent_src1    (ent_src1),
        .ent_src2    (ent_src2),
        .grant       (grant),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_pc    (issue_pc),
        .issue_dest  (issue_dest),
        .issue_src1  (issue_src1),
        .issue_src2  (issue_src2)
    );

endmodule

// File: design/rs_dispatch_ctrl.sv
`timescale 1ns/1ps
`include "div_rs_cfg.svh"

module rs_dispatch_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dispatch_req,
    input  logic [`RS_ENTRIES-1:0] busy,
    output logic                   dispatch_ack,
    output logic [`RS_ENTRIES-1:0] alloc
);

    import div_rs_pkg::*;

    disp_state_t state;
    disp_state_t state_next;

    logic    free_found;
    rs_idx_t free_idx;
    logic    accept;

    // lowest free slot wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_found = 1'b1;
                free_idx   = rs_idx_t'(i);
            end
        end
    end

    // full station holds off the ack
    assign accept = (state == disp_idle) && dispatch_req && free_found;

    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            alloc[i] = accept && (free_idx == rs_idx_t'(i));
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            disp_idle: begin
                if (accept) begin
                    state_next = disp_ack;
                end
            end
            disp_ack: begin
                state_next = dispatch_req ? disp_release : disp_idle;
            end
            disp_release: begin
                if (!dispatch_req) begin
                    state_next = disp_idle;
                end
            end
            default: begin
                state_next = disp_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= disp_idle;
        end else begin
            state <= state_next;
        end
    end

    // straight from the state register, no glitches
    assign dispatch_ack = (state != disp_idle);

endmodule

// File: design/rs_entry.sv
`timescale 1ns/1ps
`include "div_rs_cfg.svh"

module rs_entry (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      alloc,
    input  div_rs_pkg::div_op_t                       disp_op,
    input  div_rs_pkg::pc_t                           disp_pc,
    input  div_rs_pkg::tag_t                          disp_dest,
    input  div_rs_pkg::tag_t                          disp_src1_tag,
    input  div_rs_pkg::data_t                         disp_src1_data,
    input  logic                                      disp_src1_valid,
    input  div_rs_pkg::tag_t                          disp_src2_tag,
    input  div_rs_pkg::data_t                         disp_src2_data,
    input  logic                                      disp_src2_valid,
    input  logic [`RS_NUM_BUS-1:0]                    bus_valid,
    input  div_rs_pkg::tag_t  [`RS_NUM_BUS-1:0]       bus_tag,
    input  div_rs_pkg::data_t [`RS_NUM_BUS-1:0]       bus_data,
    input  logic                                      grant,
    output logic                                      busy,
    output logic                                      ready,
    output div_rs_pkg::div_op_t                       ent_op,
    output div_rs_pkg::pc_t                           ent_pc,
    output div_rs_pkg::tag_t                          ent_dest,
    output div_rs_pkg::data_t                         ent_src1,
    output div_rs_pkg::data_t                         ent_src2
);

    import div_rs_pkg::*;

    tag_t  src1_tag;
    tag_t  src2_tag;
    logic  src1_valid;
    logic  src2_valid;

    tag_t  look1;
    tag_t  look2;
    logic  hit1;
    logic  hit2;
    data_t bdata1;
    data_t bdata2;

    // on alloc the incoming tags are snooped, so a same-cycle broadcast is caught
    assign look1 = alloc ? disp_src1_tag : src1_tag;
    assign look2 = alloc ? disp_src2_tag : src2_tag;

    always_comb begin
        hit1   = 1'b0;
        hit2   = 1'b0;
        bdata1 = '0;
        bdata2 = '0;
        for (int b = 0; b < `RS_NUM_BUS; b++) begin
            if (bus_valid[b] && bus_tag[b] == look1) begin
                hit1   = 1'b1;
                bdata1 = bus_data[b];
            end
            if (bus_valid[b] && bus_tag[b] == look2) begin
                hit2   = 1'b1;
                bdata2 = bus_data[b];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            src1_valid <= 1'b0;
            src2_valid <= 1'b0;
        end else if (alloc) begin
            busy       <= 1'b1;
            src1_valid <= disp_src1_valid | hit1;
            src2_valid <= disp_src2_valid | hit2;
        end else begin
            if (grant) begin
                busy <= 1'b0;
            end
            if (busy && !src1_valid && hit1) begin
                src1_valid <= 1'b1;
            end
            if (busy && !src2_valid && hit2) begin
                src2_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_op   <= disp_op;
            ent_pc   <= disp_pc;
            ent_dest <= disp_dest;
            src1_tag <= disp_src1_tag;
            src2_tag <= disp_src2_tag;
            ent_src1 <= (!disp_src1_valid && hit1) ? bdata1 : disp_src1_data;
            ent_src2 <= (!disp_src2_valid && hit2) ? bdata2 : disp_src2_data;
        end else if (busy) begin
            if (!src1_valid && hit1) begin
                ent_src1 <= bdata1;  // wakeup
            end
            if (!src2_valid && hit2) begin
                ent_src2 <= bdata2;
            end
        end
    end

    assign ready = busy && src1_valid && src2_valid;

endmodule

// File: design/rs_issue_select.sv
`timescale 1ns/1ps
`include "div_rs_cfg.svh"

module rs_issue_select (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic [`RS_ENTRIES-1:0]                     ready,
    input  div_rs_pkg::div_op_t [`RS_ENTRIES-1:0]      ent_op,
    input  div_rs_pkg::pc_t     [`RS_ENTRIES-1:0]      ent_pc,
    input  div_rs_pkg::tag_t    [`RS_ENTRIES-1:0]      ent_dest,
    input  div_rs_pkg::data_t   [`RS_ENTRIES-1:0]      ent_src1,
    input  div_rs_pkg::data_t   [`RS_ENTRIES-1:0]      ent_src2,
    output logic [`RS_ENTRIES-1:0]                     grant,
    output logic                                       issue_valid,
    output div_rs_pkg::div_op_t                        issue_op,
    output div_rs_pkg::pc_t                            issue_pc,
    output div_rs_pkg::tag_t                           issue_dest,
    output div_rs_pkg::data_t                          issue_src1,
    output div_rs_pkg::data_t                          issue_src2
);

    import div_rs_pkg::*;

    rs_idx_t head;
    rs_idx_t sel;
    rs_idx_t head_next;
    logic    found;

    // scan upward from head with wraparound, first ready wins
    always_comb begin
        found = 1'b0;
        sel   = head;
        for (int k = 0; k < `RS_ENTRIES; k++) begin
            if (!found && ready[(int'(head) + k) % `RS_ENTRIES]) begin
                found = 1'b1;
                sel   = rs_idx_t'((int'(head) + k) % `RS_ENTRIES);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            grant[i] = found && (sel == rs_idx_t'(i));
        end
    end

    // one past the winner
    assign head_next = rs_idx_t'((int'(sel) + 1) % `RS_ENTRIES);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head        <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= found;  // single-cycle pulse per issue
            if (found) begin
                head <= head_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            issue_op   <= ent_op[sel];
            issue_pc   <= ent_pc[sel];
            issue_dest <= ent_dest[sel];
            issue_src1 <= ent_src1[sel];
            issue_src2 <= ent_src2[sel];
        end
    end

endmodule

// File: div_rs.f
+incdir+include
design/div_rs_pkg.sv
design/rs_dispatch_ctrl.sv
design/rs_entry.sv
design/rs_issue_select.sv
design/div_rs_top.sv
sim/div_rs_checker.sv
sim/div_rs_monitor.sv
sim/div_rs_tb.sv

// File: include/div_rs_cfg.svh
`ifndef DIV_RS_CFG_SVH
`define DIV_RS_CFG_SVH

// station depth, must fit in RS_IDX_W bits
`define RS_ENTRIES 16
`define RS_IDX_W 4

// physical register tag
`define RS_TAG_W 8

// operand and result width
`define RS_DATA_W 32

`define RS_PC_W 32

// alu, mul, div, load
`define RS_NUM_BUS 4

`endif

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f div_rs.f --top-module div_rs_tb -Mdir obj_dir &&
    ./obj_dir/Vdiv_rs_tb | tee /dev/stderr | grep -q "Simulation completed successfully" &&
    echo "RUN PASSED" ||
    { echo "RUN FAILED"; exit 1; }

// File: sim/div_rs_checker.sv
`timescale 1ns/1ps

module div_rs_checker (
    input logic clk,
    input logic reset,
    input logic dispatch_req,
    input logic dispatch_ack,
    input logic issue_valid
);

    int failures = 0;

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(dispatch_ack) |-> $past(dispatch_req))
        else begin
            $error("dispatch_ack rose without dispatch_req high the cycle before");
            failures++;
        end

    // ack may only drop after req has dropped
    ack_held: assert property (@(posedge clk) disable iff (reset)
        (dispatch_ack && dispatch_req) |=> dispatch_ack)
        else begin
            $error("dispatch_ack fell while dispatch_req was still high");
            failures++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        reset |-> (!issue_valid && !dispatch_ack))
        else begin
            $error("issue_valid or dispatch_ack high during reset");
            failures++;
        end

endmodule

bind div_rs_top div_rs_checker i_checker (
    .clk          (clk),
    .reset        (reset),
    .dispatch_req (dispatch_req),
    .dispatch_ack (dispatch_ack),
    .issue_valid  (issue_valid)
);

// File: sim/div_rs_monitor.sv
`timescale 1ns/1ps

module div_rs_monitor (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue_valid,
    input  div_rs_pkg::div_op_t issue_op,
    input  div_rs_pkg::pc_t     issue_pc,
    input  div_rs_pkg::tag_t    issue_dest,
    input  div_rs_pkg::data_t   issue_src1,
    input  div_rs_pkg::data_t   issue_src2,
    input  logic                test_end,
    output int                  cur_seen,
    output int                  cur_exp,
    output int                  errors,
    output int                  tests_passed,
    output int                  tests_failed
);

    import div_rs_pkg::*;

    logic [31:0] exp_op[$];
    logic [31:0] exp_pc[$];
    logic [31:0] exp_dest[$];
    logic [31:0] exp_src1[$];
    logic [31:0] exp_src2[$];
    int          exp_test[$];
    int          test_exp[0:63];
    int          cur_test;
    int          cursor;
    int          test_errors;

    // expected issues come from the E lines, one test per X line
    initial begin
        int fd;
        int code;
        int cnt;
        int n;
        string line;
        logic [31:0] op, pc, dest, s1, s2;
        n = 0;
        for (int t = 0; t < 64; t++) begin
            test_exp[t] = 0;
        end
        fd = $fopen("sim/div_rs_tests.txt", "r");
        while (fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.getc(0) == "E") begin
                code = $sscanf(line.substr(1, line.len() - 1), "%d %h %h %h %h %h",
                               cnt, op, pc, dest, s1, s2);
                for (int i = 0; i < cnt; i++) begin
                    exp_op.push_back(op);
                    exp_pc.push_back(pc + 32'(4 * i));
                    exp_dest.push_back(dest + 32'(i));
                    exp_src1.push_back(s1);
                    exp_src2.push_back(s2);
                    exp_test.push_back(n);
                end
                test_exp[n] = test_exp[n] + cnt;
            end else if (code > 0 && line.getc(0) == "X") begin
                n++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    end

    assign cur_exp = test_exp[cur_test];

    task automatic check_field(string name, logic [31:0] expv, logic [31:0] actv);
        if (expv !== actv) begin
            $display("Error at %0t ns: %s expected %h actual %h", $time, name, expv, actv);
            test_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            cur_test    = 0;
            cursor      = 0;
            cur_seen    = 0;
            test_errors = 0;
        end else begin
            if (issue_valid) begin
                if (cursor < exp_test.size() && exp_test[cursor] == cur_test) begin
                    check_field("issue_op", exp_op[cursor], 32'(issue_op));
                    check_field("issue_pc", exp_pc[cursor], issue_pc);
                    check_field("issue_dest", exp_dest[cursor], 32'(issue_dest));
                    check_field("issue_src1", exp_src1[cursor], issue_src1);
                    check_field("issue_src2", exp_src2[cursor], issue_src2);
                    cursor++;
                    cur_seen++;
                end else begin
                    $display("test %0d: unexpected extra issue at %0t ns, pc %h",
                             cur_test, $time, issue_pc);
                    test_errors++;
                end
            end
            if (test_end) begin
                if (cur_seen < test_exp[cur_test]) begin
                    $display("test %0d: issues missing, only %0d of %0d arrived",
                             cur_test, cur_seen, test_exp[cur_test]);
                    test_errors++;
                end
                while (cursor < exp_test.size() && exp_test[cursor] == cur_test) begin
                    cursor++;  // skip what never came
                end
                $display("test %0d: %s, %0d of %0d issues", cur_test,
                         (test_errors == 0) ? "PASS" : "FAIL", cur_seen, test_exp[cur_test]);
                if (test_errors == 0) begin
                    tests_passed++;
                end else begin
                    tests_failed++;
                end
                errors      = errors + test_errors;
                test_errors = 0;
                cur_seen    = 0;
                cur_test++;
            end
        end
    end

endmodule

// File: sim/div_rs_tb.sv
`timescale 1ns/1ps
`include "div_rs_cfg.svh"

module div_rs_tb;

    import div_rs_pkg::*;

    logic                      clk;
    logic                      reset;
    logic                      dispatch_req;
    div_op_t                   disp_op;
    pc_t                       disp_pc;
    tag_t                      disp_dest;
    tag_t                      disp_src1_tag;
    data_t                     disp_src1_data;
    logic                      disp_src1_valid;
    tag_t                      disp_src2_tag;
    data_t                     disp_src2_data;
    logic                      disp_src2_valid;
    logic [`RS_NUM_BUS-1:0]    bus_valid;
    tag_t [`RS_NUM_BUS-1:0]    bus_tag;
    data_t [`RS_NUM_BUS-1:0]   bus_data;
    logic                      dispatch_ack;
    logic                      issue_valid;
    div_op_t                   issue_op;
    pc_t                       issue_pc;
    tag_t                      issue_dest;
    data_t                     issue_src1;
    data_t                     issue_src2;

    logic test_end;
    logic hs_busy;   // handshake still in flight
    logic ack_seen;  // ack observed for the current request
    int   cur_seen, cur_exp, mon_errors, tests_passed, tests_failed;
    int   tb_errors = 0;
    int   cycles = 0;
    int   cycle_limit = 1000000;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    div_rs_top i_div_rs_top (.*);

    div_rs_monitor i_monitor (
        .clk (clk), .reset (reset), .issue_valid (issue_valid), .issue_op (issue_op),
        .issue_pc (issue_pc), .issue_dest (issue_dest), .issue_src1 (issue_src1),
        .issue_src2 (issue_src2), .test_end (test_end), .cur_seen (cur_seen),
        .cur_exp (cur_exp), .errors (mon_errors), .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the station stopped making progress", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // advance one clock and change inputs 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
        bus_valid = '0;
        test_end  = 1'b0;
        if (dispatch_req && dispatch_ack) begin
            if (ack_seen) begin
                dispatch_req = 1'b0;  // req stays up one cycle past the ack
            end
            ack_seen = 1'b1;
        end else if (!dispatch_req && !dispatch_ack) begin
            hs_busy = 1'b0;
        end
    endtask

    task automatic send_dispatch(string args);
        int          code, cnt;
        logic [31:0] op, pc, dest, t1, d1, v1, t2, d2, v2;
        code = $sscanf(args, "%d %h %h %h %h %h %h %h %h %h",
                       cnt, op, pc, dest, t1, d1, v1, t2, d2, v2);
        for (int i = 0; i < cnt; i++) begin
            while (hs_busy) begin
                tick();
            end
            disp_op         = div_op_t'(op[1:0]);
            disp_pc         = pc + 32'(4 * i);
            disp_dest       = dest[7:0] + 8'(i);
            disp_src1_tag   = t1[7:0];
            disp_src1_data  = d1;
            disp_src1_valid = v1[0];
            disp_src2_tag   = t2[7:0];
            disp_src2_data  = d2;
            disp_src2_valid = v2[0];
            ack_seen        = 1'b0;
            dispatch_req    = 1'b1;
            hs_busy         = 1'b1;
        end
    endtask

    task automatic close_test();
        while (hs_busy || cur_seen < cur_exp) begin
            tick();
        end
        repeat (1 + int'($urandom % 4)) tick();
        test_end = 1'b1;
        tick();
    endtask

    initial begin
        int          fd, code, n, b, sum_w, n_disp;
        logic [31:0] tg, dt;
        string       line, rest;
        string       lines[$];
        byte         kind;
        void'($urandom(17742));
        sum_w   = 0;
        n_disp  = 0;
        reset = 1'b1;
        dispatch_req = 1'b0;
        disp_op = op_div;
        disp_pc = '0;
        disp_dest = '0;
        disp_src1_tag = '0;
        disp_src1_data = '0;
        disp_src1_valid = 1'b0;
        disp_src2_tag = '0;
        disp_src2_data = '0;
        disp_src2_valid = 1'b0;
        bus_valid = '0;
        bus_tag = '0;
        bus_data = '0;
        test_end = 1'b0;
        hs_busy = 1'b0;
        ack_seen = 1'b0;
        fd = $fopen("sim/div_rs_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/div_rs_tests.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 1) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        foreach (lines[i]) begin
            rest = lines[i].substr(1, lines[i].len() - 1);
            code = $sscanf(rest, "%d", n);
            if (lines[i].getc(0) == "W") sum_w = sum_w + n;
            if (lines[i].getc(0) == "D") n_disp = n_disp + n;
        end
        cycle_limit = 2 * sum_w + 8 * n_disp;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (lines[i]) begin
            kind = lines[i].getc(0);
            rest = lines[i].substr(1, lines[i].len() - 1);
            case (kind)
                "D": send_dispatch(rest);
                "B": begin
                    code = $sscanf(rest, "%d %h %h", b, tg, dt);
                    bus_valid[b] = 1'b1;  // held for this cycle only
                    bus_tag[b]   = tg[7:0];
                    bus_data[b]  = dt;
                end
                "W": begin
                    code = $sscanf(rest, "%d", n);
                    repeat (n) tick();
                end
                "A": begin
                    code = $sscanf(rest, "%d", n);
                    if (ack_seen !== n[0]) begin
                        $display("Error at %0t ns: dispatch_ack expected %0d actual %b",
                                 $time, n, ack_seen);
                        tb_errors++;
                    end
                end
                "X": close_test();
                default: ;
            endcase
        end
        repeat (2) tick();
        n = mon_errors + tb_errors + i_div_rs_top.i_checker.failures;
        $display("%0d tests passed, %0d tests failed, %0d errors", tests_passed, tests_failed, n);
        if (n == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim/div_rs_tests.txt
# D count op pc dest src1_tag src1_data src1_valid src2_tag src2_data src2_valid
# B bus tag data, W cycles, A ack, E count op pc dest src1 src2, X ends a test
# both operands valid at dispatch
D 1 0 00001000 10 00 00000064 1 00 00000007 1
D 1 3 00001004 11 00 ffffff9c 1 00 00000005 1
W 4
E 1 0 00001000 10 00000064 00000007
E 1 3 00001004 11 ffffff9c 00000005
X
# wakeup from the buses, second entry keeps waiting
D 1 1 00002000 20 31 00000000 0 00 00000009 1
D 1 2 00002004 21 00 00000100 1 32 0000dead 0
W 3
B 1 31 0000abcd
B 0 33 00000bad
W 4
B 2 32 00001234
W 4
E 1 1 00002000 20 0000abcd 00000009
E 1 2 00002004 21 00000100 00001234
X
# broadcast in the dispatch cycle
D 1 0 00003000 30 41 00000000 0 00 00000003 1
B 3 41 00000777
W 4
E 1 0 00003000 30 00000777 00000003
X
# four wake together, head is 1 here
D 4 2 00004000 40 50 00000000 0 00 00000008 1
W 2
B 0 50 00000fff
W 8
E 3 2 00004004 41 00000fff 00000008
E 1 2 00004000 40 00000fff 00000008
X
# full station, 17th request waits for a free slot
D 5 1 00005000 80 70 00000000 0 00 00000002 1
D 1 1 00005014 85 65 00000000 0 00 00000002 1
D 10 1 00005018 86 70 00000000 0 00 00000002 1
D 1 3 00005040 90 00 00000011 1 00 00000022 1
W 4
A 0
B 0 65 00000055
W 8
B 1 70 00000077
W 4
E 1 1 00005014 85 00000055 00000002
E 1 3 00005040 90 00000011 00000022
E 10 1 00005018 86 00000077 00000002
E 5 1 00005000 80 00000077 00000002
X
